// File: verilog/mips_config.svh
`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

// Datapath and address width
`define MIPS_XLEN 32

// Register file geometry
`define MIPS_RADDR_W 5
`define MIPS_NREGS 32

`endif

// File: verilog/mips_pkg.sv
`default_nettype none

`include "mips_config.svh"

package mips_pkg;

    // Primary opcodes, bits 31:26
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDI  = 6'h08,
        OP_ORI   = 6'h0d,
        OP_LUI   = 6'h0f
    } opcode_e;

    // R-type function codes, bits 5:0
    typedef enum logic [5:0] {
        FN_ADD = 6'h20,
        FN_SUB = 6'h22,
        FN_AND = 6'h24,
        FN_OR  = 6'h25,
        FN_SLT = 6'h2a
    } funct_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,
        ALU_LUI
    } alu_op_e;

    typedef struct packed {
        logic    alu_src;
        alu_op_e alu_op;
        logic    reg_dst;
        logic    branch;
        logic    nbranch;
        logic    jump;
    } ex_ctrl_t;

    typedef struct packed {
        logic reg_write;
    } wb_ctrl_t;

    typedef struct packed {
        logic [`MIPS_XLEN-1:0]    pc4;
        logic [25:0]              jidx;
        logic [`MIPS_XLEN-1:0]    rdata1;
        logic [`MIPS_XLEN-1:0]    rdata2;
        logic [`MIPS_XLEN-1:0]    imm_ext;
        logic [`MIPS_RADDR_W-1:0] rt;
        logic [`MIPS_RADDR_W-1:0] rd;
        ex_ctrl_t                 ex_ctrl;
        wb_ctrl_t                 wb_ctrl;
    } id_ex_t;

    typedef struct packed {
        logic [`MIPS_XLEN-1:0]    result;
        logic [`MIPS_RADDR_W-1:0] dest;
        wb_ctrl_t                 wb_ctrl;
    } ex_wb_t;

endpackage

`default_nettype wire

// File: verilog/id_control_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_config.svh"

module id_control_unit
    import mips_pkg::*;
(
    input  logic [`MIPS_XLEN-1:0] i_instr,
    output ex_ctrl_t              o_ex_ctrl,
    output wb_ctrl_t              o_wb_ctrl,
    output logic [`MIPS_XLEN-1:0] o_imm_ext
);

    opcode_e     opcode;
    funct_e      funct;
    logic [15:0] imm16;

    assign opcode = opcode_e'(i_instr[31:26]);
    assign funct  = funct_e'(i_instr[5:0]);
    assign imm16  = i_instr[15:0];

    // ORI is the only zero-extended immediate
    assign o_imm_ext = (opcode == OP_ORI) ? {{(`MIPS_XLEN-16){1'b0}}, imm16}
                                          : {{(`MIPS_XLEN-16){imm16[15]}}, imm16};

    always_comb
    begin
        o_ex_ctrl = '{alu_src: 1'b0, alu_op: ALU_ADD, reg_dst: 1'b0,
                      branch: 1'b0, nbranch: 1'b0, jump: 1'b0};
        o_wb_ctrl = '{reg_write: 1'b0};
        case (opcode)
            OP_RTYPE:
            begin
                o_ex_ctrl.reg_dst   = 1'b1;
                o_wb_ctrl.reg_write = 1'b1;
                case (funct)
                    FN_ADD: o_ex_ctrl.alu_op = ALU_ADD;
                    FN_SUB: o_ex_ctrl.alu_op = ALU_SUB;
                    FN_AND: o_ex_ctrl.alu_op = ALU_AND;
                    FN_OR:  o_ex_ctrl.alu_op = ALU_OR;
                    FN_SLT: o_ex_ctrl.alu_op = ALU_SLT;
                    // Unknown funct becomes a no-op
                    default: o_wb_ctrl.reg_write = 1'b0;
                endcase
            end
            OP_ADDI:
            begin
                o_ex_ctrl.alu_src   = 1'b1;
                o_wb_ctrl.reg_write = 1'b1;
            end
            OP_ORI:
            begin
                o_ex_ctrl.alu_src   = 1'b1;
                o_ex_ctrl.alu_op    = ALU_OR;
                o_wb_ctrl.reg_write = 1'b1;
            end
            OP_LUI:
            begin
                o_ex_ctrl.alu_src   = 1'b1;
                o_ex_ctrl.alu_op    = ALU_LUI;
                o_wb_ctrl.reg_write = 1'b1;
            end
            OP_BEQ:
            begin
                o_ex_ctrl.alu_op = ALU_SUB;
                o_ex_ctrl.branch = 1'b1;
            end
            OP_BNE:
            begin
                o_ex_ctrl.alu_op  = ALU_SUB;
                o_ex_ctrl.nbranch = 1'b1;
            end
            OP_J:    o_ex_ctrl.jump = 1'b1;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/register_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_config.svh"

module register_file
(
    input  logic                     i_clk,
    input  logic                     i_rst_n,
    input  logic [`MIPS_RADDR_W-1:0] i_raddr1,
    input  logic [`MIPS_RADDR_W-1:0] i_raddr2,
    input  logic [`MIPS_RADDR_W-1:0] i_waddr,
    input  logic                     i_we,
    input  logic [`MIPS_XLEN-1:0]    i_wdata,
    output logic [`MIPS_XLEN-1:0]    o_rdata1,
    output logic [`MIPS_XLEN-1:0]    o_rdata2
);

    logic [`MIPS_XLEN-1:0] regs [`MIPS_NREGS];

    // r0 reads zero, a same-cycle write is passed straight through
    function automatic logic [`MIPS_XLEN-1:0] read_port(input logic [`MIPS_RADDR_W-1:0] addr);
        if (addr == '0)
            return '0;
        else if (i_we && addr == i_waddr)
            return i_wdata;
        else
            return regs[addr];
    endfunction

    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
        begin
            for (int i = 0; i < `MIPS_NREGS; i++)
                regs[i] <= '0;
        end
        else if (i_we && i_waddr != '0)
            regs[i_waddr] <= i_wdata;
    end

    always_comb
    begin
        o_rdata1 = read_port(i_raddr1);
        o_rdata2 = read_port(i_raddr2);
    end

endmodule

`default_nettype wire

// File: verilog/pipeline_reg.sv
`timescale 1ns/1ps
`default_nettype none

module pipeline_reg
#(
    parameter type payload_t = logic
)
(
    input  logic     i_clk,
    input  logic     i_rst_n,
    input  logic     i_valid,
    input  logic     i_hold,
    input  logic     i_flush,
    input  payload_t i_data,
    output logic     o_valid,
    output payload_t o_data
);

    // Hold wins over flush so a stalled stage keeps its instruction
    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
            o_valid <= 1'b0;
        else if (!i_hold)
            o_valid <= i_valid & ~i_flush;
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_hold)
            o_data <= i_data;
    end

endmodule

`default_nettype wire

// File: verilog/ex_alu_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_config.svh"

module ex_alu_stage
    import mips_pkg::*;
(
    input  logic                  i_valid,
    input  id_ex_t                i_id_ex,
    output ex_wb_t                o_ex_wb,
    output logic                  o_result_we,
    output logic                  o_redirect,
    output logic [`MIPS_XLEN-1:0] o_redirect_pc
);

    logic [`MIPS_XLEN-1:0]    op_a;
    logic [`MIPS_XLEN-1:0]    op_b;
    logic [`MIPS_XLEN-1:0]    result;
    logic [`MIPS_RADDR_W-1:0] dest;
    logic                     equal;
    logic [`MIPS_XLEN-1:0]    branch_pc;
    logic [`MIPS_XLEN-1:0]    jump_pc;

    assign op_a = i_id_ex.rdata1;
    assign op_b = i_id_ex.ex_ctrl.alu_src ? i_id_ex.imm_ext : i_id_ex.rdata2;

    always_comb
    begin
        case (i_id_ex.ex_ctrl.alu_op)
            ALU_ADD: result = op_a + op_b;
            ALU_SUB: result = op_a - op_b;
            ALU_AND: result = op_a & op_b;
            ALU_OR:  result = op_a | op_b;
            ALU_SLT: result = {{(`MIPS_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_LUI: result = i_id_ex.imm_ext << 16;
            default: result = '0;
        endcase
    end

    assign dest = i_id_ex.ex_ctrl.reg_dst ? i_id_ex.rd : i_id_ex.rt;

    // Writes to r0 are dropped here
    assign o_result_we = i_valid & i_id_ex.wb_ctrl.reg_write & (dest != '0);

    assign o_ex_wb = '{result: result, dest: dest, wb_ctrl: '{reg_write: o_result_we}};

    // Branch compare uses both register operands
    assign equal     = (i_id_ex.rdata1 == i_id_ex.rdata2);
    assign branch_pc = i_id_ex.pc4 + (i_id_ex.imm_ext << 2);
    assign jump_pc   = {i_id_ex.pc4[`MIPS_XLEN-1 -: 4], i_id_ex.jidx, 2'b00};

    assign o_redirect = i_valid & (i_id_ex.ex_ctrl.jump
                                   | (i_id_ex.ex_ctrl.branch & equal)
                                   | (i_id_ex.ex_ctrl.nbranch & ~equal));

    assign o_redirect_pc = i_id_ex.ex_ctrl.jump ? jump_pc : branch_pc;

endmodule

`default_nettype wire

// File: verilog/id_ex_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_config.svh"

module id_ex_core
    import mips_pkg::*;
(
    input  logic                     i_clk,
    input  logic                     i_rst_n,
    input  logic                     i_valid,
    input  logic                     i_stall,
    input  logic [`MIPS_XLEN-1:0]    i_instr,
    input  logic [`MIPS_XLEN-1:0]    i_pc4,
    output logic                     o_ex_valid,
    output logic [`MIPS_XLEN-1:0]    o_ex_result,
    output logic [`MIPS_RADDR_W-1:0] o_ex_dest,
    output logic                     o_ex_we,
    output logic                     o_redirect,
    output logic [`MIPS_XLEN-1:0]    o_redirect_pc
);

    ex_ctrl_t              ex_ctrl;
    wb_ctrl_t              wb_ctrl;
    logic [`MIPS_XLEN-1:0] imm_ext;
    logic [`MIPS_XLEN-1:0] rdata1;
    logic [`MIPS_XLEN-1:0] rdata2;
    id_ex_t                id_ex_d;
    id_ex_t                id_ex_q;
    ex_wb_t                ex_wb_d;
    ex_wb_t                ex_wb_q;
    logic                  ex_wb_valid;

    id_control_unit u_ctrl (
        .i_instr   (i_instr),
        .o_ex_ctrl (ex_ctrl),
        .o_wb_ctrl (wb_ctrl),
        .o_imm_ext (imm_ext)
    );

    register_file u_regs (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_raddr1 (i_instr[25:21]),
        .i_raddr2 (i_instr[20:16]),
        .i_waddr  (ex_wb_q.dest),
        .i_we     (ex_wb_valid & ex_wb_q.wb_ctrl.reg_write),
        .i_wdata  (ex_wb_q.result),
        .o_rdata1 (rdata1),
        .o_rdata2 (rdata2)
    );

    always_comb
    begin
        id_ex_d = '{pc4: i_pc4, jidx: i_instr[25:0], rdata1: rdata1, rdata2: rdata2,
                    imm_ext: imm_ext, rt: i_instr[20:16], rd: i_instr[15:11],
                    ex_ctrl: ex_ctrl, wb_ctrl: wb_ctrl};
    end

    // Squash the slot behind a taken branch or jump
    pipeline_reg #(.payload_t(id_ex_t)) u_id_ex (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_valid (i_valid),
        .i_hold  (i_stall),
        .i_flush (o_redirect),
        .i_data  (id_ex_d),
        .o_valid (o_ex_valid),
        .o_data  (id_ex_q)
    );

    ex_alu_stage u_ex (
        .i_valid       (o_ex_valid),
        .i_id_ex       (id_ex_q),
        .o_ex_wb       (ex_wb_d),
        .o_result_we   (o_ex_we),
        .o_redirect    (o_redirect),
        .o_redirect_pc (o_redirect_pc)
    );

    assign o_ex_result = ex_wb_d.result;
    assign o_ex_dest   = ex_wb_d.dest;

    // Bubble into write-back while ID/EX is frozen
    pipeline_reg #(.payload_t(ex_wb_t)) u_ex_wb (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_valid (o_ex_valid & ~i_stall),
        .i_hold  (1'b0),
        .i_flush (1'b0),
        .i_data  (ex_wb_d),
        .o_valid (ex_wb_valid),
        .o_data  (ex_wb_q)
    );

endmodule

`default_nettype wire

// File: verification/id_ex_core_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_config.svh"

module id_ex_core_checker
(
    input logic                     i_clk,
    input logic                     i_rst_n,
    input logic                     i_ex_valid,
    input logic                     i_ex_we,
    input logic [`MIPS_RADDR_W-1:0] i_ex_dest,
    input logic                     i_redirect
);

    // Read by the testbench at the end of the run
    int failures = 0;

    a_we_valid: assert property (@(posedge i_clk) disable iff (!i_rst_n) i_ex_we |-> i_ex_valid)
        else
        begin
            failures++;
            $error("o_ex_we high without o_ex_valid");
        end

    a_we_dest: assert property (@(posedge i_clk) disable iff (!i_rst_n)
                                i_ex_we |-> i_ex_dest != '0)
        else
        begin
            failures++;
            $error("o_ex_we high with r0 as destination");
        end

    a_redirect_valid: assert property (@(posedge i_clk) disable iff (!i_rst_n)
                                       i_redirect |-> i_ex_valid)
        else
        begin
            failures++;
            $error("o_redirect high without o_ex_valid");
        end

    // Synchronous reset clears the stage valid on the reset edge
    a_reset_clear: assert property (@(posedge i_clk) !i_rst_n |=> !i_ex_valid)
        else
        begin
            failures++;
            $error("o_ex_valid high in the cycle after reset");
        end

endmodule

bind id_ex_core id_ex_core_checker u_checker (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_ex_valid (o_ex_valid),
    .i_ex_we    (o_ex_we),
    .i_ex_dest  (o_ex_dest),
    .i_redirect (o_redirect)
);

`default_nettype wire

// File: verification/id_ex_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_config.svh"

module id_ex_core_tb
    import mips_pkg::*;
();

    localparam int CLK_PERIOD = 4;
    // Instructions issued by all tests together
    localparam int NUM_ISSUED = 31;

    logic                     clk;
    logic                     rst_n;
    logic                     valid;
    logic                     stall;
    logic [`MIPS_XLEN-1:0]    instr;
    logic [`MIPS_XLEN-1:0]    pc4;
    logic                     ex_valid;
    logic [`MIPS_XLEN-1:0]    ex_result;
    logic [`MIPS_RADDR_W-1:0] ex_dest;
    logic                     ex_we;
    logic                     redirect;
    logic [`MIPS_XLEN-1:0]    redirect_pc;

    // Reference model state and the expected outputs of the current slot
    logic [`MIPS_XLEN-1:0]    model_regs [`MIPS_NREGS];
    logic [`MIPS_XLEN-1:0]    model_pc4;
    logic [31:0]              rng_state;
    logic                     exp_valid;
    logic                     exp_we;
    logic                     exp_redir;
    logic [`MIPS_XLEN-1:0]    exp_result;
    logic [`MIPS_RADDR_W-1:0] exp_dest;
    logic [`MIPS_XLEN-1:0]    exp_pc;
    int                       errors;
    int                       checks;

    id_ex_core dut (
        .i_clk         (clk),
        .i_rst_n       (rst_n),
        .i_valid       (valid),
        .i_stall       (stall),
        .i_instr       (instr),
        .i_pc4         (pc4),
        .o_ex_valid    (ex_valid),
        .o_ex_result   (ex_result),
        .o_ex_dest     (ex_dest),
        .o_ex_we       (ex_we),
        .o_redirect    (redirect),
        .o_redirect_pc (redirect_pc)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial
    begin
        #(NUM_ISSUED * 40 * CLK_PERIOD + 200);
        $display("Watchdog expired before the tests finished");
        $display("Simulation FAILED");
        $finish;
    end

    function automatic logic [31:0] next_random();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    function automatic logic [31:0] reg_instr(input funct_e fn, input logic [4:0] rs,
                                              input logic [4:0] rt, input logic [4:0] rd);
        return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] imm_instr(input opcode_e op, input logic [4:0] rs,
                                              input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] jump_instr(input logic [25:0] idx);
        return {OP_J, idx};
    endfunction

    task automatic predict(input logic [31:0] ins);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sext;
        a          = model_regs[ins[25:21]];
        b          = model_regs[ins[20:16]];
        sext       = {{16{ins[15]}}, ins[15:0]};
        exp_valid  = 1'b1;
        exp_dest   = ins[20:16];
        exp_redir  = 1'b0;
        exp_result = '0;
        exp_pc     = model_pc4 + (sext << 2);
        case (ins[31:26])
            OP_RTYPE:
            begin
                exp_dest = ins[15:11];
                case (ins[5:0])
                    FN_ADD:  exp_result = a + b;
                    FN_SUB:  exp_result = a - b;
                    FN_AND:  exp_result = a & b;
                    FN_OR:   exp_result = a | b;
                    default: exp_result = {31'd0, $signed(a) < $signed(b)};
                endcase
            end
            OP_ADDI: exp_result = a + sext;
            OP_ORI:  exp_result = a | {16'd0, ins[15:0]};
            OP_LUI:  exp_result = {ins[15:0], 16'd0};
            OP_BEQ:  exp_redir = (a == b);
            OP_BNE:  exp_redir = (a != b);
            default:
            begin
                exp_redir = 1'b1;
                exp_pc    = {model_pc4[31:28], ins[25:0], 2'b00};
            end
        endcase
        exp_we = (ins[31:26] inside {OP_RTYPE, OP_ADDI, OP_ORI, OP_LUI}) && exp_dest != '0;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        checks++;
        assert (got === want)
        else
        begin
            errors++;
            $display("** Error at %0t ns: %s expected %h, got %h", $time, name, want, got);
        end
    endtask

    task automatic check_outputs();
        check_value("o_ex_valid", ex_valid, exp_valid);
        check_value("o_ex_we", ex_we, exp_valid & exp_we);
        check_value("o_redirect", redirect, exp_valid & exp_redir);
        if (exp_valid && exp_we)
        begin
            check_value("o_ex_result", ex_result, exp_result);
            check_value("o_ex_dest", ex_dest, exp_dest);
        end
        if (exp_valid && exp_redir)
            check_value("o_redirect_pc", redirect_pc, exp_pc);
    endtask

    task automatic next_cycle();
        @(posedge clk);
        @(negedge clk);
    endtask

    task automatic issue(input logic [31:0] ins);
        predict(ins);
        valid = 1'b1;
        instr = ins;
        pc4   = model_pc4;
        next_cycle();
        check_outputs();
        model_pc4 += 4;
        if (exp_we)
            model_regs[exp_dest] = exp_result;
    endtask

    // Empty slot after an instruction, or a squashed one after a redirect
    task automatic settle();
        valid     = exp_redir;
        instr     = imm_instr(OP_ADDI, 5'd0, 5'd20, 16'h0001);
        exp_valid = 1'b0;
        next_cycle();
        check_outputs();
        valid = 1'b0;
    endtask

    task automatic run(input logic [31:0] ins);
        issue(ins);
        settle();
    endtask

    task automatic test_reset();
        exp_valid = 1'b0;
        // Offer an instruction that reset must keep out of ID/EX
        valid     = 1'b1;
        instr     = imm_instr(OP_ADDI, 5'd0, 5'd1, 16'h0001);
        repeat (3)
        begin
            @(negedge clk);
            check_outputs();
        end
        rst_n = 1'b1;
        valid = 1'b0;
        repeat (2)
        begin
            next_cycle();
            check_outputs();
        end
    endtask

    task automatic test_alu();
        funct_e      fns [5] = '{FN_ADD, FN_SUB, FN_AND, FN_OR, FN_SLT};
        logic [31:0] v;
        for (int r = 1; r <= 4; r++)
        begin
            v = next_random();
            run(imm_instr(OP_LUI, 5'd0, 5'(r), v[31:16]));
            run(imm_instr(OP_ORI, 5'(r), 5'(r), v[15:0]));
        end
        v = next_random();
        run(imm_instr(OP_ADDI, 5'd1, 5'd5, v[15:0]));
        for (int k = 0; k < 10; k++)
        begin
            v = next_random();
            run(reg_instr(fns[k % 5], 5'(1 + v[2:0] % 5), 5'(1 + v[5:3] % 5), 5'(6 + k % 5)));
        end
    endtask

    task automatic test_r0();
        run(imm_instr(OP_ADDI, 5'd1, 5'd0, 16'h1234));
        run(reg_instr(FN_OR, 5'd2, 5'd3, 5'd0));
        run(reg_instr(FN_ADD, 5'd0, 5'd0, 5'd11));
        run(reg_instr(FN_OR, 5'd0, 5'd3, 5'd12));
    endtask

    task automatic test_branches();
        logic [31:0] v;
        v = next_random();
        run(imm_instr(OP_BEQ, 5'd1, 5'd1, v[15:0]));
        run(imm_instr(OP_BEQ, 5'd1, 5'd2, 16'h0010));
        run(imm_instr(OP_BNE, 5'd3, 5'd4, 16'hfff0));
        run(imm_instr(OP_BNE, 5'd5, 5'd5, v[31:16]));
        run(jump_instr(v[25:0]));
        // r20 stays zero when the squashed ADDI never reaches write-back
        run(reg_instr(FN_OR, 5'd20, 5'd0, 5'd21));
    endtask

    task automatic test_stall();
        logic [31:0] v;
        v = next_random();
        issue(imm_instr(OP_ADDI, 5'd14, 5'd14, v[15:0]));
        stall = 1'b1;
        instr = imm_instr(OP_ADDI, 5'd14, 5'd14, 16'h0001);
        repeat (4)
        begin
            next_cycle();
            check_outputs();
        end
        stall = 1'b0;
        settle();
        run(reg_instr(FN_ADD, 5'd14, 5'd14, 5'd15));
    endtask

    initial
    begin
        rng_state = 32'd76549;
        errors    = 0;
        checks    = 0;
        model_pc4 = 32'h0040_0004;
        for (int r = 0; r < `MIPS_NREGS; r++)
            model_regs[r] = '0;
        rst_n = 1'b0;
        valid = 1'b0;
        stall = 1'b0;
        instr = '0;
        pc4   = '0;
        test_reset();
        test_alu();
        test_r0();
        test_branches();
        test_stall();
        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, dut.u_checker.failures);
        if (errors == 0 && dut.u_checker.failures == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
+incdir+verilog
verilog/mips_pkg.sv
verilog/id_control_unit.sv
verilog/register_file.sv
verilog/pipeline_reg.sv
verilog/ex_alu_stage.sv
verilog/id_ex_core.sv
verification/id_ex_core_checker.sv
verification/id_ex_core_tb.sv

// File: Bender.yml
package:
  name: id_ex_core

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/mips_pkg.sv
      - verilog/id_control_unit.sv
      - verilog/register_file.sv
      - verilog/pipeline_reg.sv
      - verilog/ex_alu_stage.sv
      - verilog/id_ex_core.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - verification/id_ex_core_checker.sv
      - verification/id_ex_core_tb.sv
